//--- verilog.f
+incdir+tests
design/cu_pkg.sv
design/instr_decoder.sv
design/ext_decoder.sv
design/byte_sequencer.sv
design/control_unit.sv
tests/cu_tb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - design/cu_pkg.sv
  - design/instr_decoder.sv
  - design/ext_decoder.sv
  - design/byte_sequencer.sv
  - design/control_unit.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cu_tb.sv

//--- tests/cu_model.svh
// Expected control words, built from the decode rules of the control unit
// bits[10] picks PC_JUMP over PC_INC, bits[9:5] are out_sel_alu branch_taken sp_inc_sel
// rd2_old_rb out_port_en, bits[4:0] are dmem_we dmem_re regf_we is_ret sp_inc
function automatic ctrl_t pack_ctrl(input rdata_sel_t rd, input dmem_wd_sel_t wd,
	input dmem_a_sel_t da, input addr_sel_t wa, input logic [10:0] bits, input alu_op_t alu);
	pc_sel_t pc;
	pc = bits[10] ? PC_JUMP : PC_INC;
	return {rd, wd, da, bits[9], pc, wa, bits[8:0], alu}; // Field order of ctrl_t
endfunction

// ALU result written back to a register
function automatic ctrl_t alu_result(input addr_sel_t wa, input alu_op_t alu);
	return pack_ctrl(RD_RESULT, WD_NONE, DA_RA, wa, 'b0_10000_00100, alu);
endfunction

// Word for one opcode byte outside a two-byte sequence
function automatic ctrl_t expect_single(input byte_t b, input flags_t f);
	logic [3:0] op;
	logic [1:0] ra;
	logic [3:0] fv;
	ctrl_t      e;
	op = b[7:4];
	ra = b[3:2];
	fv = f; // Bit 0 is z, then n, c and v in ra order
	e  = CTRL_IDLE;
	case ({op, ra})
		{4'h6, 2'd0}: e = alu_result(WA_RB, ALU_RLC);
		{4'h6, 2'd1}: e = alu_result(WA_RB, ALU_RRC);
		{4'h6, 2'd2}: e = pack_ctrl(RD_SP, WD_NONE, DA_RA, WA_RA, '0, ALU_SETC);
		{4'h6, 2'd3}: e = pack_ctrl(RD_SP, WD_NONE, DA_RA, WA_RA, '0, ALU_CLRC);
		{4'h7, 2'd0}: e = pack_ctrl(RD_SP, WD_RB, DA_SP, WA_SP, 'b0_00000_10100, ALU_PUSH);
		{4'h7, 2'd1}: e = pack_ctrl(RD_RESULT, WD_NONE, DA_SP_INC, WA_RB, 'b0_00100_01101, ALU_POP);
		{4'h7, 2'd2}: e = pack_ctrl(RD_SP, WD_NONE, DA_RA, WA_RA, 'b0_00001_00000, ALU_OUT);
		{4'h7, 2'd3}: e = pack_ctrl(RD_INPORT, WD_NONE, DA_RA, WA_RB, 'b0_00000_00100, ALU_IN);
		{4'hB, 2'd0}: e = pack_ctrl(RD_SP, WD_NONE, DA_RA, WA_RA, 'b1_11000_00000, ALU_PASS_RD2);
		{4'hB, 2'd1}: e = pack_ctrl(RD_SP, WD_PC1, DA_SP, WA_SP, 'b1_11000_10100, ALU_CALL);
		{4'hB, 2'd2}: e = pack_ctrl(RD_SP, WD_NONE, DA_SP_INC, WA_SP, 'b1_00100_01110, ALU_RET);
		{4'hB, 2'd3}: e = CTRL_IDLE; // Former RTI
		default: begin
			if (op >= 4'd1 && op <= 4'd5)
				e = alu_result(WA_RA, alu_op_t'({2'b00, op}));
			else if (op == 4'd8)
				e = alu_result(WA_RB, alu_op_t'(6'd14 + ra)); // NOT NEG INC DEC
			else if (op == 4'd9 && fv[ra])
				e = pack_ctrl(RD_SP, WD_NONE, DA_RA, WA_RA, 'b1_11000_00000, ALU_PASS_RD2);
			else if (op == 4'd9)
				e = pack_ctrl(RD_SP, WD_NONE, DA_RA, WA_RA, '0, alu_op_t'(6'd18 + ra));
			else if (op == 4'd13)
				e = pack_ctrl(RD_RESULT, WD_NONE, DA_RA, WA_RB, 'b0_00000_01100, ALU_LDI);
			else if (op == 4'd14)
				e = pack_ctrl(RD_SP, WD_RB, DA_RA, WA_RA, 'b0_00000_10000, ALU_STI);
		end
	endcase
	return e;
endfunction

// Second-byte word, chosen by ra of the latched first byte
function automatic ctrl_t expect_ext(input reg_sel_t ra);
	ctrl_t e;
	case (ra)
		2'd0: e = pack_ctrl(RD_IMM, WD_NONE, DA_RA, WA_OLD_RB, 'b0_10000_00100, ALU_LDM);
		2'd1: e = pack_ctrl(RD_RESULT, WD_NONE, DA_EA, WA_OLD_RB, 'b0_00000_01100, ALU_LDD);
		2'd2: e = pack_ctrl(RD_SP, WD_RB, DA_EA, WA_RA, 'b0_00010_10000, ALU_STD);
		default: e = CTRL_IDLE;
	endcase
	return e;
endfunction

//--- tests/cu_tb.sv
`timescale 1ns/1ps

module cu_tb import cu_pkg::*; ();

	localparam int N_RANDOM   = 2000;
	localparam int MAX_CYCLES = 2500; // Reset, 375 directed cycles, random stream, margin

	logic     clk;
	logic     rst;
	byte_t    opcode;
	flags_t   flags;
	ctrl_t    ctrl;
	logic     is_2byte;
	reg_sel_t old_rb;

	bit       in_second; // Model sequencer state
	bit [7:0] held;      // Model copy of the first byte
	ctrl_t    exp_ctrl;
	logic     exp_2byte;
	reg_sel_t exp_old_rb;
	int       cycles;
	int       ctrl_errs, stall_errs, rb_errs;

	`include "cu_model.svh"

	control_unit dut0 (
		.clk      (clk),
		.rst      (rst),
		.opcode   (opcode),
		.flags    (flags),
		.ctrl     (ctrl),
		.is_2byte (is_2byte),
		.old_rb   (old_rb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Second byte never starts another sequence
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			in_second <= 1'b0;
			held      <= '0;
		end else if (in_second) begin
			in_second <= 1'b0;
		end else if (opcode[7:4] == 4'd12) begin
			in_second <= 1'b1;
			held      <= opcode;
		end
	end

	always_comb begin
		exp_ctrl   = expect_single(opcode, flags);
		exp_2byte  = 1'b0;
		exp_old_rb = '0;
		if (!rst) begin
			exp_ctrl = CTRL_RESET;
		end else if (in_second) begin
			exp_ctrl   = expect_ext(held[3:2]);
			exp_old_rb = held[1:0];
		end else if (opcode[7:4] == 4'd12) begin
			exp_ctrl  = CTRL_IDLE; // Bubble for the first byte
			exp_2byte = 1'b1;
		end
	end

	ctrl_match: assert property (@(posedge clk) ctrl == exp_ctrl)
		else begin
			ctrl_errs++;
			$display("ERR %0t ctrl got %h exp %h, alu_op %0d exp %0d", $time, $sampled(ctrl),
				$sampled(exp_ctrl), $sampled(ctrl.alu_op), $sampled(exp_ctrl.alu_op));
		end

	stall_match: assert property (@(posedge clk) is_2byte == exp_2byte)
		else begin
			stall_errs++;
			$display("ERR %0t is_2byte got %b exp %b", $time, $sampled(is_2byte),
				$sampled(exp_2byte));
		end

	old_rb_match: assert property (@(posedge clk) old_rb == exp_old_rb)
		else begin
			rb_errs++;
			$display("ERR %0t old_rb got %0d exp %0d", $time, $sampled(old_rb),
				$sampled(exp_old_rb));
		end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: stimulus still running after %0d clock cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// One clock cycle per call
	task automatic drive(input byte_t b, input logic [3:0] f);
		@(negedge clk);
		opcode = b;
		flags  = f;
		#1;
		second_no_stall: assert (!(in_second && is_2byte))
			else begin
				stall_errs++;
				$display("ERR %0t is_2byte raised in a second-byte cycle", $time);
			end
	endtask

	initial begin
		void'($urandom(98886));
		rst    = 1'b0;
		opcode = 8'hC0; // Two-byte op held in reset
		flags  = '0;
		repeat (5) @(negedge clk);
		rst    = 1'b1;
		opcode = 8'h00; // NOP for the first cycle out of reset
		for (int i = 0; i < 256; i++)
			drive(8'(i), 4'($urandom)); // Every byte once
		for (int i = 0; i < 64; i++)
			drive(8'(144 + 4 * (i / 16)), 4'(i)); // Each branch against all flag values
		for (int i = 0; i < 16; i++) begin
			drive(8'(192 + i), 4'($urandom));
			drive(8'(192 + $urandom % 64), 4'($urandom)); // Operand byte with op 12 to 15
			drive(8'h00, 4'h0);
		end
		drive(8'hC1, 4'h0);
		drive(8'hC6, 4'h0);
		drive(8'hC9, 4'h0); // Straight after a second byte
		drive(8'hCE, 4'h0);
		drive(8'hC7, 4'h0);
		drive(8'hF2, 4'h0);
		for (int i = 0; i < N_RANDOM; i++)
			drive(8'($urandom), 4'($urandom));
		@(posedge clk);
		#1;
		$display("Errors: ctrl %0d, is_2byte %0d, old_rb %0d", ctrl_errs, stall_errs, rb_errs);
		if (ctrl_errs + stall_errs + rb_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- design/control_unit.sv
`timescale 1ns/1ps

module control_unit import cu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  byte_t    opcode,
	input  flags_t   flags,
	output ctrl_t    ctrl,
	output logic     is_2byte,
	output reg_sel_t old_rb
);

	ctrl_t  single_ctrl;
	ctrl_t  ext_ctrl;
	instr_t first_byte; // Latched LDM/LDD/STD byte

	instr_decoder u_instr_decoder (
		.opcode      (opcode),
		.flags       (flags),
		.single_ctrl (single_ctrl)
	);

	ext_decoder u_ext_decoder (
		.first_byte (first_byte),
		.ext_ctrl   (ext_ctrl)
	);

	byte_sequencer u_byte_sequencer (
		.clk         (clk),
		.rst         (rst),
		.opcode      (opcode),
		.single_ctrl (single_ctrl),
		.ext_ctrl    (ext_ctrl),
		.first_byte  (first_byte),
		.ctrl        (ctrl),
		.is_2byte    (is_2byte),
		.old_rb      (old_rb)
	);

endmodule

//--- design/byte_sequencer.sv
`timescale 1ns/1ps

module byte_sequencer import cu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  byte_t    opcode,
	input  ctrl_t    single_ctrl,
	input  ctrl_t    ext_ctrl,
	output instr_t   first_byte,
	output ctrl_t    ctrl,
	output logic     is_2byte,
	output reg_sel_t old_rb
);

	cu_state_t state;
	cu_state_t state_next;
	instr_t    cur;
	logic      start_2byte; // First byte of LDM/LDD/STD seen

	assign cur         = instr_t'(opcode);
	assign start_2byte = (state == IDLE) && (cur.op == OP_TWO_BYTE);

	always_comb begin
		case (state)
			IDLE:    state_next = start_2byte ? SECOND_BYTE : IDLE;
			default: state_next = IDLE; // Second byte never chains
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Holds op, ra and rb for the second-byte cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			first_byte <= '0;
		end else if (start_2byte) begin
			first_byte <= cur;
		end
	end

	always_comb begin
		ctrl     = single_ctrl;
		is_2byte = 1'b0;
		old_rb   = '0;
		if (!rst) begin
			ctrl = CTRL_RESET;
		end else if (state == SECOND_BYTE) begin
			ctrl   = ext_ctrl;
			old_rb = first_byte.rb;
		end else if (start_2byte) begin
			ctrl     = CTRL_IDLE; // Bubble while the operand byte arrives
			is_2byte = 1'b1;      // Stall request
		end
	end

endmodule

//--- design/ext_decoder.sv
`timescale 1ns/1ps

module ext_decoder import cu_pkg::*; (
	input  instr_t first_byte,
	output ctrl_t  ext_ctrl
);

	// Second-byte cycle, the current byte is imm or ea
	always_comb begin
		ext_ctrl = CTRL_IDLE;
		case (first_byte.ra)
			2'd0: begin // LDM, R[rb] <- imm
				ext_ctrl.alu_op      = ALU_LDM;
				ext_ctrl.regf_we     = 1'b1;
				ext_ctrl.rdata_sel   = RD_IMM;
				ext_ctrl.out_sel_alu = 1'b1;
				ext_ctrl.addr_sel    = WA_OLD_RB;
			end

			2'd1: begin // LDD, R[rb] <- M[ea]
				ext_ctrl.alu_op     = ALU_LDD;
				ext_ctrl.regf_we    = 1'b1;
				ext_ctrl.dmem_re    = 1'b1;
				ext_ctrl.rdata_sel  = RD_RESULT;
				ext_ctrl.dmem_a_sel = DA_EA;
				ext_ctrl.addr_sel   = WA_OLD_RB;
			end

			2'd2: begin // STD, M[ea] <- R[rb]
				ext_ctrl.alu_op      = ALU_STD;
				ext_ctrl.dmem_we     = 1'b1;
				ext_ctrl.dmem_wd_sel = WD_RB;
				ext_ctrl.dmem_a_sel  = DA_EA;
				ext_ctrl.rd2_old_rb  = 1'b1; // Read port 2 from latched rb
			end

			default: ext_ctrl = CTRL_IDLE;
		endcase
	end

endmodule

//--- design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import cu_pkg::*; (
	input  byte_t  opcode,
	input  flags_t flags,
	output ctrl_t  single_ctrl
);

	instr_t ins;
	logic   flag_hit; // Flag picked by the branch selector

	assign ins = instr_t'(opcode);

	// Register write of an ALU result
	function automatic ctrl_t alu_write(input alu_op_t op, input addr_sel_t dst);
		ctrl_t c;
		c             = CTRL_IDLE;
		c.regf_we     = 1'b1;
		c.out_sel_alu = 1'b1;
		c.rdata_sel   = RD_RESULT;
		c.addr_sel    = dst;
		c.alu_op      = op;
		return c;
	endfunction

	// PC loaded from R[rb] passed through the ALU
	function automatic ctrl_t jump_taken(input alu_op_t op);
		ctrl_t c;
		c              = CTRL_IDLE;
		c.alu_op       = op;
		c.out_sel_alu  = 1'b1;
		c.pc_sel       = PC_JUMP;
		c.branch_taken = 1'b1;
		return c;
	endfunction

	always_comb begin
		case (ins.ra)
			2'd0:    flag_hit = flags.z;
			2'd1:    flag_hit = flags.n;
			2'd2:    flag_hit = flags.c;
			default: flag_hit = flags.v;
		endcase
	end

	always_comb begin
		single_ctrl = CTRL_IDLE;
		case (ins.op)
			OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR: begin
				single_ctrl = alu_write(alu_op_t'({2'b00, ins.op}), WA_RA); // alu_op follows op
			end

			OP_SHIFT: begin
				case (ins.ra)
					2'd0:    single_ctrl = alu_write(ALU_RLC, WA_RB);
					2'd1:    single_ctrl = alu_write(ALU_RRC, WA_RB);
					2'd2:    single_ctrl.alu_op = ALU_SETC; // Carry only
					default: single_ctrl.alu_op = ALU_CLRC;
				endcase
			end

			OP_STACK: begin
				case (ins.ra)
					2'd0: begin // PUSH, store then SP--
						single_ctrl.alu_op      = ALU_PUSH;
						single_ctrl.dmem_we     = 1'b1;
						single_ctrl.dmem_wd_sel = WD_RB;
						single_ctrl.dmem_a_sel  = DA_SP;
						single_ctrl.regf_we     = 1'b1;
						single_ctrl.rdata_sel   = RD_SP;
						single_ctrl.addr_sel    = WA_SP;
					end
					2'd1: begin // POP, ++SP then load
						single_ctrl.alu_op     = ALU_POP;
						single_ctrl.dmem_re    = 1'b1;
						single_ctrl.regf_we    = 1'b1;
						single_ctrl.sp_inc_sel = 1'b1;
						single_ctrl.sp_inc     = 1'b1;
						single_ctrl.dmem_a_sel = DA_SP_INC;
						single_ctrl.rdata_sel  = RD_RESULT; // Memory side of the result mux
						single_ctrl.addr_sel   = WA_RB;
					end
					2'd2: begin
						single_ctrl.alu_op      = ALU_OUT;
						single_ctrl.out_port_en = 1'b1;
					end
					default: begin
						single_ctrl.alu_op    = ALU_IN;
						single_ctrl.regf_we   = 1'b1;
						single_ctrl.rdata_sel = RD_INPORT;
						single_ctrl.addr_sel  = WA_RB;
					end
				endcase
			end

			OP_UNARY: begin
				single_ctrl = alu_write(alu_op_t'(ALU_NOT + {4'b0000, ins.ra}), WA_RB);
			end

			OP_BRANCH: begin
				if (flag_hit)
					single_ctrl = jump_taken(ALU_PASS_RD2);
				else
					single_ctrl.alu_op = alu_op_t'(ALU_JZ + {4'b0000, ins.ra}); // Not taken
			end

			OP_JUMP: begin
				case (ins.ra)
					2'd0: single_ctrl = jump_taken(ALU_PASS_RD2); // JMP
					2'd1: begin // CALL pushes PC+1
						single_ctrl             = jump_taken(ALU_CALL);
						single_ctrl.dmem_we     = 1'b1;
						single_ctrl.dmem_wd_sel = WD_PC1;
						single_ctrl.dmem_a_sel  = DA_SP;
						single_ctrl.regf_we     = 1'b1;
						single_ctrl.rdata_sel   = RD_SP;
						single_ctrl.addr_sel    = WA_SP;
					end
					2'd2: begin // RET pops the PC
						single_ctrl.alu_op     = ALU_RET;
						single_ctrl.dmem_re    = 1'b1;
						single_ctrl.regf_we    = 1'b1;
						single_ctrl.is_ret     = 1'b1;
						single_ctrl.sp_inc_sel = 1'b1;
						single_ctrl.dmem_a_sel = DA_SP_INC;
						single_ctrl.rdata_sel  = RD_SP;
						single_ctrl.addr_sel   = WA_SP;
						single_ctrl.pc_sel     = PC_JUMP;
					end
					default: single_ctrl = CTRL_IDLE; // Old RTI slot
				endcase
			end

			OP_LDI: begin // R[rb] <- M[R[ra]]
				single_ctrl.alu_op     = ALU_LDI;
				single_ctrl.dmem_re    = 1'b1;
				single_ctrl.regf_we    = 1'b1;
				single_ctrl.dmem_a_sel = DA_RA;
				single_ctrl.rdata_sel  = RD_RESULT;
				single_ctrl.addr_sel   = WA_RB;
			end

			OP_STI: begin // M[R[ra]] <- R[rb]
				single_ctrl.alu_op      = ALU_STI;
				single_ctrl.dmem_we     = 1'b1;
				single_ctrl.dmem_wd_sel = WD_RB;
				single_ctrl.dmem_a_sel  = DA_RA;
			end

			default: single_ctrl = CTRL_IDLE; // NOP, 10, 12 and 15
		endcase
	end

endmodule

//--- design/cu_pkg.sv
package cu_pkg;

	localparam int BYTE_W    = 8;
	localparam int OP_W      = 4;
	localparam int REG_SEL_W = 2;
	localparam int ALU_OP_W  = 6;
	localparam int SEL_W     = 2; // All datapath mux selects

	typedef logic [BYTE_W-1:0]    byte_t;
	typedef logic [OP_W-1:0]      opcode_t;
	typedef logic [REG_SEL_W-1:0] reg_sel_t;

	// Opcode byte layout, op in the upper nibble
	typedef struct packed {
		opcode_t  op;
		reg_sel_t ra; // Also branch or sub-operation selector
		reg_sel_t rb;
	} instr_t;

	typedef struct packed {
		logic v;
		logic c;
		logic n;
		logic z;
	} flags_t;

	// Main opcodes
	localparam opcode_t OP_MOV      = 4'd1;
	localparam opcode_t OP_ADD      = 4'd2;
	localparam opcode_t OP_SUB      = 4'd3;
	localparam opcode_t OP_AND      = 4'd4;
	localparam opcode_t OP_OR       = 4'd5;
	localparam opcode_t OP_SHIFT    = 4'd6;  // RLC RRC SETC CLRC
	localparam opcode_t OP_STACK    = 4'd7;  // PUSH POP OUT IN
	localparam opcode_t OP_UNARY    = 4'd8;  // NOT NEG INC DEC
	localparam opcode_t OP_BRANCH   = 4'd9;  // JZ JN JC JV
	localparam opcode_t OP_JUMP     = 4'd11; // JMP CALL RET
	localparam opcode_t OP_TWO_BYTE = 4'd12; // LDM LDD STD
	localparam opcode_t OP_LDI      = 4'd13;
	localparam opcode_t OP_STI      = 4'd14;

	typedef enum logic [ALU_OP_W-1:0] {
		ALU_NOP      = 6'd0,
		ALU_MOV      = 6'd1,
		ALU_ADD      = 6'd2,
		ALU_SUB      = 6'd3,
		ALU_AND      = 6'd4,
		ALU_OR       = 6'd5,
		ALU_RLC      = 6'd6,
		ALU_RRC      = 6'd7,
		ALU_SETC     = 6'd8,
		ALU_CLRC     = 6'd9,
		ALU_PUSH     = 6'd10,
		ALU_POP      = 6'd11,
		ALU_OUT      = 6'd12,
		ALU_IN       = 6'd13,
		ALU_NOT      = 6'd14,
		ALU_NEG      = 6'd15,
		ALU_INC      = 6'd16,
		ALU_DEC      = 6'd17,
		ALU_JZ       = 6'd18,
		ALU_JN       = 6'd19,
		ALU_JC       = 6'd20,
		ALU_JV       = 6'd21,
		ALU_PASS_RD2 = 6'd23,
		ALU_CALL     = 6'd24,
		ALU_RET      = 6'd25,
		ALU_LDM      = 6'd27,
		ALU_LDD      = 6'd28,
		ALU_STD      = 6'd29,
		ALU_LDI      = 6'd30,
		ALU_STI      = 6'd31
	} alu_op_t;

	typedef enum logic [SEL_W-1:0] {
		PC_INC    = 2'd0,
		PC_RESET  = 2'd1, // Fetch from M[0]
		PC_VECTOR = 2'd2, // Interrupt vector, kept for the encoding
		PC_JUMP   = 2'd3
	} pc_sel_t;

	typedef enum logic [SEL_W-1:0] {
		WA_RA     = 2'd0,
		WA_RB     = 2'd1,
		WA_SP     = 2'd2,
		WA_OLD_RB = 2'd3  // rb of a latched first byte
	} addr_sel_t;

	typedef enum logic [SEL_W-1:0] {
		RD_SP     = 2'd0, // Updated stack pointer
		RD_INPORT = 2'd1,
		RD_RESULT = 2'd2, // ALU or memory, see out_sel_alu
		RD_IMM    = 2'd3
	} rdata_sel_t;

	typedef enum logic [SEL_W-1:0] {
		WD_NONE = 2'd0,
		WD_RB   = 2'd1,
		WD_PC1  = 2'd2,
		WD_PC   = 2'd3
	} dmem_wd_sel_t;

	typedef enum logic [SEL_W-1:0] {
		DA_RA     = 2'd0,
		DA_SP     = 2'd1,
		DA_SP_INC = 2'd2,
		DA_EA     = 2'd3  // Second byte as address
	} dmem_a_sel_t;

	typedef struct packed {
		rdata_sel_t   rdata_sel;
		dmem_wd_sel_t dmem_wd_sel;
		dmem_a_sel_t  dmem_a_sel;
		logic         out_sel_alu; // 1 picks ALU, 0 picks data memory
		pc_sel_t      pc_sel;
		addr_sel_t    addr_sel;
		logic         branch_taken;
		logic         sp_inc_sel;  // 1 increments SP, 0 decrements
		logic         rd2_old_rb;
		logic         out_port_en;
		logic         dmem_we;
		logic         dmem_re;
		logic         regf_we;
		logic         is_ret;
		logic         sp_inc;
		alu_op_t      alu_op;
	} ctrl_t;

	localparam ctrl_t CTRL_IDLE = '{
		rdata_sel:    RD_SP,
		dmem_wd_sel:  WD_NONE,
		dmem_a_sel:   DA_RA,
		out_sel_alu:  1'b0,
		pc_sel:       PC_INC,
		addr_sel:     WA_RA,
		branch_taken: 1'b0,
		sp_inc_sel:   1'b0,
		rd2_old_rb:   1'b0,
		out_port_en:  1'b0,
		dmem_we:      1'b0,
		dmem_re:      1'b0,
		regf_we:      1'b0,
		is_ret:       1'b0,
		sp_inc:       1'b0,
		alu_op:       ALU_NOP
	};

	// Idle word that reloads the PC from M[0]
	localparam ctrl_t CTRL_RESET = '{
		rdata_sel:    RD_SP,
		dmem_wd_sel:  WD_NONE,
		dmem_a_sel:   DA_RA,
		out_sel_alu:  1'b0,
		pc_sel:       PC_RESET,
		addr_sel:     WA_RA,
		branch_taken: 1'b0,
		sp_inc_sel:   1'b0,
		rd2_old_rb:   1'b0,
		out_port_en:  1'b0,
		dmem_we:      1'b0,
		dmem_re:      1'b0,
		regf_we:      1'b0,
		is_ret:       1'b0,
		sp_inc:       1'b0,
		alu_op:       ALU_NOP
	};

	typedef enum logic {
		IDLE,
		SECOND_BYTE
	} cu_state_t;

endpackage
